// File: design/wb_video_pkg.sv
package wb_video_pkg;

    // ##################################################
    // Pixel and gain formats
    // ##################################################
    localparam int PIX_W     = 8;
    localparam int GAIN_W    = 16;
    localparam int GAIN_FRAC = 8;                                    // Q8.8 fraction bits

    localparam logic [GAIN_W-1:0] GAIN_UNITY = GAIN_W'(1 << GAIN_FRAC);

    // Width that holds one channel summed over a whole frame
    function automatic int sum_width(input int pix_cnt);
        return $clog2(pix_cnt) + PIX_W;
    endfunction

    // ##################################################
    // Wishbone register map
    // ##################################################
    localparam int WB_ADR_W = 3;
    localparam int WB_DAT_W = 32;

    localparam logic [WB_ADR_W-1:0] REG_CTRL   = 3'd0;               // Bit 0 enable, bit 1 update
    localparam logic [WB_ADR_W-1:0] REG_AVG_R  = 3'd1;
    localparam logic [WB_ADR_W-1:0] REG_AVG_G  = 3'd2;
    localparam logic [WB_ADR_W-1:0] REG_AVG_B  = 3'd3;
    localparam logic [WB_ADR_W-1:0] REG_FRAMES = 3'd4;

endpackage : wb_video_pkg

// File: design/wb_ctrl_regs.sv
`timescale 1ns/10ps

module wb_ctrl_regs (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic                              i_wb_cyc,
    input  logic                              i_wb_stb,
    input  logic                              i_wb_we,
    input  logic [wb_video_pkg::WB_ADR_W-1:0] i_wb_adr,
    input  logic [wb_video_pkg::WB_DAT_W-1:0] i_wb_dat,
    input  logic [wb_video_pkg::PIX_W-1:0]    i_avg_r,
    input  logic [wb_video_pkg::PIX_W-1:0]    i_avg_g,
    input  logic [wb_video_pkg::PIX_W-1:0]    i_avg_b,
    input  logic                              i_gains_done,
    output logic [wb_video_pkg::WB_DAT_W-1:0] o_wb_dat,
    output logic                              o_wb_ack,
    output logic                              o_enable,
    output logic                              o_update
);
    import wb_video_pkg::*;

    logic                wb_req;
    logic [WB_DAT_W-1:0] frame_cnt;
    logic [WB_DAT_W-1:0] rd_data;

    // A held request is served once, the ack cycle blocks a second ack
    assign wb_req = i_wb_cyc & i_wb_stb & ~o_wb_ack;

    always_comb begin
        case (i_wb_adr)
            REG_CTRL:   rd_data = {{(WB_DAT_W-2){1'b0}}, o_update, o_enable};
            REG_AVG_R:  rd_data = WB_DAT_W'(i_avg_r);
            REG_AVG_G:  rd_data = WB_DAT_W'(i_avg_g);
            REG_AVG_B:  rd_data = WB_DAT_W'(i_avg_b);
            REG_FRAMES: rd_data = frame_cnt;
            default:    rd_data = '0;                                // Unmapped reads give zero
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            o_wb_ack  <= 1'b0;
            o_enable  <= 1'b0;
            o_update  <= 1'b0;
            frame_cnt <= '0;
        end else begin
            o_wb_ack <= wb_req;
            if (wb_req && i_wb_we && i_wb_adr == REG_CTRL) begin
                o_enable <= i_wb_dat[0];
                o_update <= i_wb_dat[1];
            end
            if (i_gains_done) begin
                frame_cnt <= frame_cnt + 1'b1;                       // One per completed solve
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wb_req) begin
            o_wb_dat <= rd_data;                                     // Valid in the ack cycle
        end
    end

endmodule : wb_ctrl_regs

// File: design/frame_stats.sv
`timescale 1ns/10ps

module frame_stats #(
    parameter  int H_ACT = 16,
    parameter  int V_ACT = 4,
    localparam int SUM_W = wb_video_pkg::sum_width(H_ACT * V_ACT)
) (
    input  logic                           clk,
    input  logic                           rstn,
    input  logic                           i_vsync,
    input  logic                           i_de,
    input  logic [wb_video_pkg::PIX_W-1:0] i_r,
    input  logic [wb_video_pkg::PIX_W-1:0] i_g,
    input  logic [wb_video_pkg::PIX_W-1:0] i_b,
    input  logic                           i_update,
    output logic [SUM_W-1:0]               o_sum_r,
    output logic [SUM_W-1:0]               o_sum_g,
    output logic [SUM_W-1:0]               o_sum_b,
    output logic                           o_sums_valid
);
    import wb_video_pkg::*;

    logic             vsync_q;
    logic             vsync_rise;
    logic [SUM_W-1:0] acc_r;
    logic [SUM_W-1:0] acc_g;
    logic [SUM_W-1:0] acc_b;

    assign vsync_rise = i_vsync & ~vsync_q;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            vsync_q      <= 1'b0;
            acc_r        <= '0;
            acc_g        <= '0;
            acc_b        <= '0;
            o_sums_valid <= 1'b0;
        end else begin
            vsync_q      <= i_vsync;
            o_sums_valid <= vsync_rise & i_update;
            if (vsync_rise) begin
                acc_r <= '0;                                         // New frame starts here
                acc_g <= '0;
                acc_b <= '0;
            end else if (i_de) begin
                acc_r <= acc_r + SUM_W'(i_r);
                acc_g <= acc_g + SUM_W'(i_g);
                acc_b <= acc_b + SUM_W'(i_b);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (vsync_rise && i_update) begin
            o_sum_r <= acc_r;
            o_sum_g <= acc_g;
            o_sum_b <= acc_b;
        end
    end

endmodule : frame_stats

// File: design/gain_solver.sv
`timescale 1ns/10ps

module gain_solver #(
    parameter  int H_ACT = 16,
    parameter  int V_ACT = 4,
    localparam int SUM_W = wb_video_pkg::sum_width(H_ACT * V_ACT)
) (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic [SUM_W-1:0]                i_sum_r,
    input  logic [SUM_W-1:0]                i_sum_g,
    input  logic [SUM_W-1:0]                i_sum_b,
    input  logic                            i_sums_valid,
    output logic [wb_video_pkg::PIX_W-1:0]  o_avg_r,
    output logic [wb_video_pkg::PIX_W-1:0]  o_avg_g,
    output logic [wb_video_pkg::PIX_W-1:0]  o_avg_b,
    output logic [wb_video_pkg::GAIN_W-1:0] o_gain_r,
    output logic [wb_video_pkg::GAIN_W-1:0] o_gain_g,
    output logic [wb_video_pkg::GAIN_W-1:0] o_gain_b,
    output logic                            o_gains_done
);
    import wb_video_pkg::*;

    localparam int PIX_CNT = H_ACT * V_ACT;
    localparam int DIV_W   = (SUM_W > GAIN_W) ? SUM_W : GAIN_W;
    localparam int CNT_W   = $clog2(DIV_W + 1);

    localparam logic [1:0] S_IDLE  = 2'd0;
    localparam logic [1:0] S_LOAD  = 2'd1;
    localparam logic [1:0] S_RUN   = 2'd2;
    localparam logic [1:0] S_STORE = 2'd3;

    logic [1:0]        state;
    logic [2:0]        step;                                         // Division index 0 to 6
    logic [CNT_W-1:0]  bit_cnt;
    logic [SUM_W-1:0]  sum_r_q;
    logic [SUM_W-1:0]  sum_g_q;
    logic [SUM_W-1:0]  sum_b_q;
    logic [PIX_W-1:0]  gray;
    logic [GAIN_W-1:0] new_gain_r;
    logic [GAIN_W-1:0] new_gain_g;
    logic [GAIN_W-1:0] new_gain_b;
    logic [DIV_W:0]    rem;
    logic [DIV_W:0]    rem_shift;
    logic [DIV_W-1:0]  quo;
    logic [DIV_W-1:0]  den;
    logic [DIV_W-1:0]  dividend;
    logic [DIV_W-1:0]  divisor;
    logic [PIX_W-1:0]  gain_avg;
    logic [GAIN_W-1:0] gain_q;

    // ##################################################
    // Operand select for the shared divider
    // ##################################################
    always_comb begin
        case (step)
            3'd4:    gain_avg = o_avg_r;
            3'd5:    gain_avg = o_avg_g;
            default: gain_avg = o_avg_b;
        endcase
    end

    always_comb begin
        dividend = DIV_W'({gray, {GAIN_FRAC{1'b0}}});                // Gray mean in Q8.8
        divisor  = DIV_W'(gain_avg);
        case (step)
            3'd0: begin
                dividend = DIV_W'(sum_r_q);
                divisor  = DIV_W'(PIX_CNT);
            end
            3'd1: begin
                dividend = DIV_W'(sum_g_q);
                divisor  = DIV_W'(PIX_CNT);
            end
            3'd2: begin
                dividend = DIV_W'(sum_b_q);
                divisor  = DIV_W'(PIX_CNT);
            end
            3'd3: begin
                dividend = DIV_W'(o_avg_r) + DIV_W'(o_avg_g) + DIV_W'(o_avg_b);
                divisor  = DIV_W'(3);
            end
            default: ;
        endcase
    end

    assign rem_shift = {rem[DIV_W-1:0], quo[DIV_W-1]};

    always_comb begin
        if (gain_avg == '0) begin
            gain_q = GAIN_UNITY;                                     // Dark channel keeps unity gain
        end else begin
            gain_q = quo[GAIN_W-1:0];
        end
    end

    // ##################################################
    // Sequencer
    // ##################################################
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state        <= S_IDLE;
            step         <= '0;
            bit_cnt      <= '0;
            o_avg_r      <= '0;
            o_avg_g      <= '0;
            o_avg_b      <= '0;
            o_gain_r     <= GAIN_UNITY;
            o_gain_g     <= GAIN_UNITY;
            o_gain_b     <= GAIN_UNITY;
            o_gains_done <= 1'b0;
        end else begin
            o_gains_done <= 1'b0;
            if (o_gains_done) begin
                o_gain_r <= new_gain_r;                              // All three switch together
                o_gain_g <= new_gain_g;
                o_gain_b <= new_gain_b;
            end
            case (state)
                S_IDLE: begin
                    if (i_sums_valid) begin
                        step  <= '0;
                        state <= S_LOAD;
                    end
                end
                S_LOAD: begin
                    bit_cnt <= CNT_W'(DIV_W);
                    state   <= S_RUN;
                end
                S_RUN: begin
                    bit_cnt <= bit_cnt - 1'b1;
                    if (bit_cnt == CNT_W'(1)) begin
                        state <= S_STORE;
                    end
                end
                default: begin
                    case (step)
                        3'd0:    o_avg_r <= quo[PIX_W-1:0];
                        3'd1:    o_avg_g <= quo[PIX_W-1:0];
                        3'd2:    o_avg_b <= quo[PIX_W-1:0];
                        default: ;
                    endcase
                    if (step == 3'd6) begin
                        state        <= S_IDLE;
                        o_gains_done <= 1'b1;
                    end else begin
                        step  <= step + 1'b1;
                        state <= S_LOAD;
                    end
                end
            endcase
        end
    end

    // Restoring divider that yields one quotient bit per cycle
    always_ff @(posedge clk) begin
        if (state == S_IDLE && i_sums_valid) begin
            sum_r_q <= i_sum_r;
            sum_g_q <= i_sum_g;
            sum_b_q <= i_sum_b;
        end
        if (state == S_LOAD) begin
            rem <= '0;
            quo <= dividend;
            den <= divisor;
        end else if (state == S_RUN) begin
            if (rem_shift >= {1'b0, den}) begin
                rem <= rem_shift - {1'b0, den};
                quo <= {quo[DIV_W-2:0], 1'b1};
            end else begin
                rem <= rem_shift;
                quo <= {quo[DIV_W-2:0], 1'b0};
            end
        end
        if (state == S_STORE) begin
            case (step)
                3'd3:    gray <= quo[PIX_W-1:0];
                3'd4:    new_gain_r <= gain_q;
                3'd5:    new_gain_g <= gain_q;
                3'd6:    new_gain_b <= gain_q;
                default: ;
            endcase
        end
    end

endmodule : gain_solver

// File: design/pixel_gain.sv
`timescale 1ns/10ps

module pixel_gain (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic                            i_hsync,
    input  logic                            i_vsync,
    input  logic                            i_de,
    input  logic [wb_video_pkg::PIX_W-1:0]  i_r,
    input  logic [wb_video_pkg::PIX_W-1:0]  i_g,
    input  logic [wb_video_pkg::PIX_W-1:0]  i_b,
    input  logic [wb_video_pkg::GAIN_W-1:0] i_gain_r,
    input  logic [wb_video_pkg::GAIN_W-1:0] i_gain_g,
    input  logic [wb_video_pkg::GAIN_W-1:0] i_gain_b,
    input  logic                            i_enable,
    output logic                            o_hsync,
    output logic                            o_vsync,
    output logic                            o_de,
    output logic [wb_video_pkg::PIX_W-1:0]  o_r,
    output logic [wb_video_pkg::PIX_W-1:0]  o_g,
    output logic [wb_video_pkg::PIX_W-1:0]  o_b
);
    import wb_video_pkg::*;

    localparam int PROD_W = PIX_W + GAIN_W;

    logic [2:0][2:0]   ctl_sr;                                       // {hsync, vsync, de} per stage
    logic [PIX_W-1:0]  s1_r, s1_g, s1_b;
    logic [PIX_W-1:0]  s2_r, s2_g, s2_b;                             // Original pixel beside products
    logic [PROD_W-1:0] prod_r, prod_g, prod_b;

    function automatic logic [PIX_W-1:0] saturate(input logic [PROD_W-1:0] prod);
        logic [PROD_W-1:0] scaled;
        scaled = prod >> GAIN_FRAC;
        if (scaled[PROD_W-1:PIX_W] != '0) begin
            return '1;
        end
        return scaled[PIX_W-1:0];
    endfunction

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ctl_sr <= '0;
        end else begin
            ctl_sr <= {ctl_sr[1:0], {i_hsync, i_vsync, i_de}};
        end
    end

    assign {o_hsync, o_vsync, o_de} = ctl_sr[2];

    always_ff @(posedge clk) begin
        s1_r   <= i_r;                                               // Stage 1
        s1_g   <= i_g;
        s1_b   <= i_b;
        s2_r   <= s1_r;                                              // Stage 2
        s2_g   <= s1_g;
        s2_b   <= s1_b;
        prod_r <= s1_r * i_gain_r;
        prod_g <= s1_g * i_gain_g;
        prod_b <= s1_b * i_gain_b;
        o_r    <= i_enable ? saturate(prod_r) : s2_r;                // Stage 3
        o_g    <= i_enable ? saturate(prod_g) : s2_g;
        o_b    <= i_enable ? saturate(prod_b) : s2_b;
    end

endmodule : pixel_gain

// File: design/white_balance_top.sv
`timescale 1ns/10ps

module white_balance_top #(
    parameter  int H_ACT = 16,
    parameter  int V_ACT = 4,
    localparam int SUM_W = wb_video_pkg::sum_width(H_ACT * V_ACT)
) (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic                              i_hsync,
    input  logic                              i_vsync,
    input  logic                              i_de,
    input  logic [wb_video_pkg::PIX_W-1:0]    i_r,
    input  logic [wb_video_pkg::PIX_W-1:0]    i_g,
    input  logic [wb_video_pkg::PIX_W-1:0]    i_b,
    input  logic                              i_wb_cyc,
    input  logic                              i_wb_stb,
    input  logic                              i_wb_we,
    input  logic [wb_video_pkg::WB_ADR_W-1:0] i_wb_adr,
    input  logic [wb_video_pkg::WB_DAT_W-1:0] i_wb_dat,
    output logic                              o_hsync,
    output logic                              o_vsync,
    output logic                              o_de,
    output logic [wb_video_pkg::PIX_W-1:0]    o_r,
    output logic [wb_video_pkg::PIX_W-1:0]    o_g,
    output logic [wb_video_pkg::PIX_W-1:0]    o_b,
    output logic [wb_video_pkg::WB_DAT_W-1:0] o_wb_dat,
    output logic                              o_wb_ack
);
    import wb_video_pkg::*;

    logic              enable;
    logic              update;
    logic [SUM_W-1:0]  sum_r, sum_g, sum_b;
    logic              sums_valid;
    logic [PIX_W-1:0]  avg_r, avg_g, avg_b;
    logic [GAIN_W-1:0] gain_r, gain_g, gain_b;
    logic              gains_done;

    wb_ctrl_regs u_wb_ctrl_regs (
        .clk(clk), .rstn(rstn),
        .i_wb_cyc(i_wb_cyc), .i_wb_stb(i_wb_stb), .i_wb_we(i_wb_we),
        .i_wb_adr(i_wb_adr), .i_wb_dat(i_wb_dat),
        .i_avg_r(avg_r), .i_avg_g(avg_g), .i_avg_b(avg_b),
        .i_gains_done(gains_done),
        .o_wb_dat(o_wb_dat), .o_wb_ack(o_wb_ack),
        .o_enable(enable), .o_update(update)
    );

    frame_stats #(.H_ACT(H_ACT), .V_ACT(V_ACT)) u_frame_stats (
        .clk(clk), .rstn(rstn),
        .i_vsync(i_vsync), .i_de(i_de), .i_r(i_r), .i_g(i_g), .i_b(i_b),
        .i_update(update),
        .o_sum_r(sum_r), .o_sum_g(sum_g), .o_sum_b(sum_b),
        .o_sums_valid(sums_valid)
    );

    gain_solver #(.H_ACT(H_ACT), .V_ACT(V_ACT)) u_gain_solver (
        .clk(clk), .rstn(rstn),
        .i_sum_r(sum_r), .i_sum_g(sum_g), .i_sum_b(sum_b),
        .i_sums_valid(sums_valid),
        .o_avg_r(avg_r), .o_avg_g(avg_g), .o_avg_b(avg_b),
        .o_gain_r(gain_r), .o_gain_g(gain_g), .o_gain_b(gain_b),
        .o_gains_done(gains_done)
    );

    pixel_gain u_pixel_gain (
        .clk(clk), .rstn(rstn),
        .i_hsync(i_hsync), .i_vsync(i_vsync), .i_de(i_de),
        .i_r(i_r), .i_g(i_g), .i_b(i_b),
        .i_gain_r(gain_r), .i_gain_g(gain_g), .i_gain_b(gain_b),
        .i_enable(enable),
        .o_hsync(o_hsync), .o_vsync(o_vsync), .o_de(o_de),
        .o_r(o_r), .o_g(o_g), .o_b(o_b)
    );

endmodule : white_balance_top

// File: sim/white_balance_assert.sv
`timescale 1ns/10ps

module white_balance_assert (
    input logic clk,
    input logic rstn,
    input logic i_cyc,
    input logic i_stb,
    input logic i_ack,
    input logic i_hsync,
    input logic i_vsync,
    input logic i_de
);

    int fail_cnt = 0;

    a_ack_pulse: assert property (@(posedge clk) disable iff (!rstn) i_ack |=> !i_ack)
        else begin
            $error("Wishbone ack held for more than one cycle");
            fail_cnt++;
        end

    a_req_ack: assert property (@(posedge clk) disable iff (!rstn)
        (i_cyc && i_stb && !i_ack) |=> i_ack)
        else begin
            $error("Wishbone request not acked on the next cycle");
            fail_cnt++;
        end

    a_no_stray_ack: assert property (@(posedge clk) disable iff (!rstn)
        i_ack |-> $past(i_cyc && i_stb))
        else begin
            $error("Wishbone ack without a request");
            fail_cnt++;
        end

    // Checked from the second reset cycle on when the asynchronous clear has settled
    a_reset_quiet: assert property (@(posedge clk)
        (!rstn && $past(!rstn)) |-> !(i_ack || i_hsync || i_vsync || i_de))
        else begin
            $error("Outputs active during reset");
            fail_cnt++;
        end

endmodule : white_balance_assert

bind wb_ctrl_regs white_balance_assert u_wb_assert (
    .clk(clk), .rstn(rstn),
    .i_cyc(i_wb_cyc), .i_stb(i_wb_stb), .i_ack(o_wb_ack),
    .i_hsync(1'b0), .i_vsync(1'b0), .i_de(1'b0)
);

bind pixel_gain white_balance_assert u_pix_assert (
    .clk(clk), .rstn(rstn),
    .i_cyc(1'b0), .i_stb(1'b0), .i_ack(1'b0),
    .i_hsync(o_hsync), .i_vsync(o_vsync), .i_de(o_de)
);

// File: sim/wb_checker.sv
`timescale 1ns/10ps

module wb_checker (
    input logic                              clk,
    input logic                              rstn,
    input logic                              i_src_hsync,
    input logic                              i_src_vsync,
    input logic                              i_src_de,
    input logic [wb_video_pkg::PIX_W-1:0]    i_exp_r,
    input logic [wb_video_pkg::PIX_W-1:0]    i_exp_g,
    input logic [wb_video_pkg::PIX_W-1:0]    i_exp_b,
    input logic                              i_dut_hsync,
    input logic                              i_dut_vsync,
    input logic                              i_dut_de,
    input logic [wb_video_pkg::PIX_W-1:0]    i_dut_r,
    input logic [wb_video_pkg::PIX_W-1:0]    i_dut_g,
    input logic [wb_video_pkg::PIX_W-1:0]    i_dut_b,
    input logic                              i_wb_cyc,
    input logic                              i_wb_stb,
    input logic                              i_wb_we,
    input logic [wb_video_pkg::WB_ADR_W-1:0] i_wb_adr,
    input logic                              i_wb_ack,
    input logic [wb_video_pkg::WB_DAT_W-1:0] i_wb_dat,
    input logic [wb_video_pkg::WB_DAT_W-1:0] i_exp_rd
);
    import wb_video_pkg::*;

    logic [2:0]         sync_sr [3];                                 // {hsync, vsync, de}
    logic [3*PIX_W-1:0] pix_sr [3];
    logic               req_q;
    int                 err_cnt    = 0;
    int                 test_err   = 0;
    int                 test_pass  = 0;
    int                 test_fail  = 0;

    task automatic count_error();
        err_cnt++;
        test_err++;
    endtask

    task automatic end_test(input string name);
        if (test_err == 0) begin
            $display("Test %s: pass", name);
            test_pass++;
        end else begin
            $display("Test %s: %0d errors", name, test_err);
            test_fail++;
        end
        test_err = 0;
    endtask

    always @(posedge clk) begin
        sync_sr[0] <= {i_src_hsync, i_src_vsync, i_src_de};
        sync_sr[1] <= sync_sr[0];
        sync_sr[2] <= sync_sr[1];
        pix_sr[0]  <= {i_exp_r, i_exp_g, i_exp_b};
        pix_sr[1]  <= pix_sr[0];
        pix_sr[2]  <= pix_sr[1];
        req_q      <= rstn & i_wb_cyc & i_wb_stb & ~i_wb_ack;
        if (rstn) begin
            if ({i_dut_hsync, i_dut_vsync, i_dut_de} != sync_sr[2]) begin
                $display("Fail %0t: sync/de got %b expected %b", $time,
                         {i_dut_hsync, i_dut_vsync, i_dut_de}, sync_sr[2]);
                count_error();
            end
            if (sync_sr[2][0] && {i_dut_r, i_dut_g, i_dut_b} != pix_sr[2]) begin
                $display("Fail %0t: pixel got %h expected %h", $time,
                         {i_dut_r, i_dut_g, i_dut_b}, pix_sr[2]);
                count_error();
            end
            if (i_wb_ack != req_q) begin
                $display("Wishbone ack at %0t did not come exactly one cycle after a request",
                         $time);
                count_error();
            end
            if (i_wb_ack && !i_wb_we && i_wb_dat != i_exp_rd) begin
                $display("Fail %0t: read of register %0d got %0h expected %0h", $time,
                         i_wb_adr, i_wb_dat, i_exp_rd);
                count_error();
            end
        end
    end

endmodule : wb_checker

// File: sim/tb_white_balance.sv
`timescale 1ns/10ps

module tb_white_balance;
    import wb_video_pkg::*;

    localparam int H_ACT      = 16;
    localparam int V_ACT      = 4;
    localparam int PIX_CNT    = H_ACT * V_ACT;
    localparam int LINE_CYC   = H_ACT + 12;
    localparam int VBLANK_CYC = 400;
    localparam int FRAME_CYC  = V_ACT * LINE_CYC + VBLANK_CYC;
    localparam int CYC_LIMIT  = 16 + 6 * FRAME_CYC + 500;           // Margin covers register traffic

    logic                clk;
    logic                rstn;
    logic                hsync, vsync, de;
    logic [PIX_W-1:0]    pix_r, pix_g, pix_b;
    logic                wb_cyc, wb_stb, wb_we;
    logic [WB_ADR_W-1:0] wb_adr;
    logic [WB_DAT_W-1:0] wb_dat_w;
    logic [WB_DAT_W-1:0] wb_dat_r;
    logic                wb_ack;
    logic                out_hsync, out_vsync, out_de;
    logic [PIX_W-1:0]    out_r, out_g, out_b;
    logic [PIX_W-1:0]    exp_r, exp_g, exp_b;
    logic [WB_DAT_W-1:0] exp_rd;

    // Reference model state
    logic [31:0]         seed;
    logic [GAIN_W-1:0]   m_gain_r, m_gain_g, m_gain_b;
    logic [PIX_W-1:0]    m_avg_r, m_avg_g, m_avg_b;
    logic                m_enable, m_update;
    int                  m_frames;
    int                  sum_r, sum_g, sum_b;
    int                  cycle_cnt = 0;
    int                  assert_fails;

    white_balance_top #(.H_ACT(H_ACT), .V_ACT(V_ACT)) UUT (
        .clk(clk), .rstn(rstn),
        .i_hsync(hsync), .i_vsync(vsync), .i_de(de),
        .i_r(pix_r), .i_g(pix_g), .i_b(pix_b),
        .i_wb_cyc(wb_cyc), .i_wb_stb(wb_stb), .i_wb_we(wb_we),
        .i_wb_adr(wb_adr), .i_wb_dat(wb_dat_w),
        .o_hsync(out_hsync), .o_vsync(out_vsync), .o_de(out_de),
        .o_r(out_r), .o_g(out_g), .o_b(out_b),
        .o_wb_dat(wb_dat_r), .o_wb_ack(wb_ack)
    );

    wb_checker u_check (
        .clk(clk), .rstn(rstn),
        .i_src_hsync(hsync), .i_src_vsync(vsync), .i_src_de(de),
        .i_exp_r(exp_r), .i_exp_g(exp_g), .i_exp_b(exp_b),
        .i_dut_hsync(out_hsync), .i_dut_vsync(out_vsync), .i_dut_de(out_de),
        .i_dut_r(out_r), .i_dut_g(out_g), .i_dut_b(out_b),
        .i_wb_cyc(wb_cyc), .i_wb_stb(wb_stb), .i_wb_we(wb_we), .i_wb_adr(wb_adr),
        .i_wb_ack(wb_ack), .i_wb_dat(wb_dat_r), .i_exp_rd(exp_rd)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == CYC_LIMIT) begin
            $display("Timeout: the run did not reach its end within %0d cycles", CYC_LIMIT);
            $display("Simulation failed");
            $finish;
        end
    end

    // ##################################################
    // Reference model
    // ##################################################
    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [GAIN_W-1:0] ref_gain(input int avg, input int gray);
        int gain;
        if (avg == 0) begin
            return 16'd256;                                          // Unity for a dark channel
        end
        gain = gray * 256 / avg;
        return (gain > 65535) ? 16'hffff : GAIN_W'(gain);
    endfunction

    function automatic logic [PIX_W-1:0] ref_pixel(input int pix, input int gain, input logic en);
        int scaled;
        scaled = (pix * gain) >> 8;
        if (!en) begin
            return PIX_W'(pix);
        end
        return (scaled > 255) ? 8'hff : PIX_W'(scaled);
    endfunction

    task automatic solve_model();
        int gray;
        m_avg_r  = PIX_W'(sum_r / PIX_CNT);
        m_avg_g  = PIX_W'(sum_g / PIX_CNT);
        m_avg_b  = PIX_W'(sum_b / PIX_CNT);
        gray     = (int'(m_avg_r) + int'(m_avg_g) + int'(m_avg_b)) / 3;
        m_gain_r = ref_gain(int'(m_avg_r), gray);
        m_gain_g = ref_gain(int'(m_avg_g), gray);
        m_gain_b = ref_gain(int'(m_avg_b), gray);
        m_frames++;
    endtask

    // ##################################################
    // Stimulus
    // ##################################################
    task automatic drive_cycle(input logic hs, input logic vs, input logic den,
                               input logic [PIX_W-1:0] pr, input logic [PIX_W-1:0] pg,
                               input logic [PIX_W-1:0] pb);
        @(posedge clk);
        hsync <= hs;
        vsync <= vs;
        de    <= den;
        pix_r <= pr;
        pix_g <= pg;
        pix_b <= pb;
        exp_r <= ref_pixel(int'(pr), int'(m_gain_r), m_enable);
        exp_g <= ref_pixel(int'(pg), int'(m_gain_g), m_enable);
        exp_b <= ref_pixel(int'(pb), int'(m_gain_b), m_enable);
    endtask

    task automatic drive_blank(input int n, input logic hs, input logic vs);
        repeat (n) drive_cycle(hs, vs, 1'b0, '0, '0, '0);
    endtask

    // Active lines come first and vsync opens the vertical blanking where the solve runs
    task automatic send_frame(input int cast_r, input int cast_g, input int cast_b);
        int               ln;
        int               px;
        logic [PIX_W-1:0] pr, pg, pb;
        sum_r = 0;
        sum_g = 0;
        sum_b = 0;
        for (ln = 0; ln < V_ACT; ln++) begin
            drive_blank(4, 1'b1, 1'b0);
            drive_blank(4, 1'b0, 1'b0);
            for (px = 0; px < H_ACT; px++) begin
                seed = lcg_next(seed);
                pr = PIX_W'((int'(seed[23:16]) * cast_r) >> 8);
                pg = PIX_W'((int'(seed[31:24]) * cast_g) >> 8);
                pb = PIX_W'((int'(seed[15:8]) * cast_b) >> 8);
                sum_r += int'(pr);
                sum_g += int'(pg);
                sum_b += int'(pb);
                drive_cycle(1'b0, 1'b0, 1'b1, pr, pg, pb);
            end
            drive_blank(4, 1'b0, 1'b0);
        end
        drive_blank(4, 1'b0, 1'b1);
        drive_blank(VBLANK_CYC - 4, 1'b0, 1'b0);
        if (m_update) begin
            solve_model();
        end
    endtask

    task automatic wait_ack();
        @(posedge clk);
        while (!wb_ack) begin
            @(posedge clk);
        end
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic wb_write(input logic [WB_ADR_W-1:0] adr, input logic [WB_DAT_W-1:0] data);
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= 1'b1;
        wb_adr   <= adr;
        wb_dat_w <= data;
        wait_ack();
    endtask

    task automatic wb_read(input logic [WB_ADR_W-1:0] adr, input logic [WB_DAT_W-1:0] expected);
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we  <= 1'b0;
        wb_adr <= adr;
        exp_rd <= expected;
        wait_ack();
    endtask

    task automatic set_ctrl(input logic en, input logic upd);
        wb_write(REG_CTRL, {30'h3fff_ffff, upd, en});                // Upper bits must be ignored
        m_enable = en;
        m_update = upd;
    endtask

    // The checker sees the last ack and its falling edge before the test closes
    task automatic report_test(input string name);
        repeat (2) @(negedge clk);
        u_check.end_test(name);
    endtask

    // ##################################################
    // Test sequence
    // ##################################################
    initial begin
        rstn     = 1'b0;
        hsync    = 1'b0;
        vsync    = 1'b0;
        de       = 1'b0;
        pix_r    = '0;
        pix_g    = '0;
        pix_b    = '0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        exp_r    = '0;
        exp_g    = '0;
        exp_b    = '0;
        exp_rd   = '0;
        seed     = 32'h015d_9d6c;
        m_gain_r = 16'd256;
        m_gain_g = 16'd256;
        m_gain_b = 16'd256;
        m_avg_r  = '0;
        m_avg_g  = '0;
        m_avg_b  = '0;
        m_enable = 1'b0;
        m_update = 1'b0;
        m_frames = 0;
        repeat (16) @(posedge clk);
        rstn <= 1'b1;

        wb_read(REG_CTRL, '0);
        wb_read(REG_AVG_R, '0);
        wb_read(REG_AVG_G, '0);
        wb_read(REG_AVG_B, '0);
        wb_read(REG_FRAMES, '0);
        send_frame(256, 256, 256);
        report_test("reset and passthrough");

        set_ctrl(1'b1, 1'b1);
        wb_read(REG_CTRL, 32'd3);
        set_ctrl(1'b0, 1'b1);
        wb_read(REG_CTRL, 32'd2);
        wb_write(REG_AVG_R, 32'h55);
        wb_read(REG_AVG_R, '0);
        wb_read(3'd7, '0);
        report_test("register access");

        send_frame(256, 160, 96);
        wb_read(REG_AVG_R, WB_DAT_W'(m_avg_r));
        wb_read(REG_AVG_G, WB_DAT_W'(m_avg_g));
        wb_read(REG_AVG_B, WB_DAT_W'(m_avg_b));
        wb_read(REG_FRAMES, WB_DAT_W'(m_frames));
        report_test("statistics");

        set_ctrl(1'b1, 1'b1);
        send_frame(240, 48, 0);                                      // Dark blue and boosted green
        wb_read(REG_AVG_B, '0);
        wb_read(REG_FRAMES, WB_DAT_W'(m_frames));
        send_frame(256, 256, 256);
        wb_read(REG_FRAMES, WB_DAT_W'(m_frames));
        report_test("correction");

        set_ctrl(1'b1, 1'b0);
        send_frame(96, 256, 200);
        send_frame(160, 200, 256);
        wb_read(REG_FRAMES, WB_DAT_W'(m_frames));
        wb_read(REG_AVG_R, WB_DAT_W'(m_avg_r));
        report_test("freeze");

        repeat (4) @(negedge clk);
        assert_fails = UUT.u_wb_ctrl_regs.u_wb_assert.fail_cnt
                     + UUT.u_pixel_gain.u_pix_assert.fail_cnt;
        $display("Tests: %0d passed, %0d failed, %0d errors, %0d assertion failures",
                 u_check.test_pass, u_check.test_fail, u_check.err_cnt, assert_fails);
        if (u_check.err_cnt == 0 && assert_fails == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule : tb_white_balance

// File: project.f
design/wb_video_pkg.sv
design/wb_ctrl_regs.sv
design/frame_stats.sv
design/gain_solver.sv
design/pixel_gain.sv
design/white_balance_top.sv
sim/white_balance_assert.sv
sim/wb_checker.sv
sim/tb_white_balance.sv

// File: Makefile
TOP := tb_white_balance

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-Mdir obj_dir -f project.f
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
		echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf obj_dir
